//--- include/rob_settings.svh
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// datapath
`define XLEN         32

// register indices, 32 architectural and 64 physical
`define AREG_BITS    5
`define PREG_BITS    6

// reorder buffer geometry
`define ROB_DEPTH    16
`define ROB_BITS     4

// completion ports from the execution units
`define CPL_PORTS    4

// retirement slots per cycle
`define RETIRE_WIDTH 2

`endif

//--- verilog/rob_pkg.sv
`include "rob_settings.svh"

package rob_pkg;

    ////////////////////////////////////////////////////////////
    // front end records
    ////////////////////////////////////////////////////////////

    // one instruction offered by dispatch
    typedef struct packed {
        logic                   valid;
        logic [`AREG_BITS-1:0]  areg;      // architectural destination
        logic                   is_store;
        logic [`XLEN-1:0]       pc;
    } dispatch_t;

    // renamed instruction, rename -> rob
    typedef struct packed {
        logic                   valid;
        logic [`AREG_BITS-1:0]  areg;
        logic [`PREG_BITS-1:0]  preg_new;  // freshly popped from free list
        logic [`PREG_BITS-1:0]  preg_old;  // previous mapping of areg
        logic                   is_store;
        logic [`XLEN-1:0]       pc;
    } rob_alloc_t;

    ////////////////////////////////////////////////////////////
    // back end records
    ////////////////////////////////////////////////////////////

    // one per completion port
    typedef struct packed {
        logic                   valid;
        logic [`ROB_BITS-1:0]   tag;
        logic [`XLEN-1:0]       data;
    } complete_t;

    // one per retirement slot
    typedef struct packed {
        logic                   valid;
        logic [`AREG_BITS-1:0]  areg;
        logic [`PREG_BITS-1:0]  preg_old;  // goes back to the free list
        logic [`XLEN-1:0]       data;
        logic [`XLEN-1:0]       pc;
        logic                   is_store;
    } retire_t;

    // stored rob record
    typedef struct packed {
        logic                   busy;      // slot holds an instruction
        logic                   done;      // result has arrived
        logic [`AREG_BITS-1:0]  areg;
        logic [`PREG_BITS-1:0]  preg_new;
        logic [`PREG_BITS-1:0]  preg_old;
        logic                   is_store;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       data;
    } rob_entry_t;

endpackage

//--- verilog/rename_unit.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module rename_unit
    import rob_pkg::*;
(
    input  logic                            clk,
    input  logic                            rstn,
    input  dispatch_t                       dispatch,   // valid already gated by stall
    input  retire_t [`RETIRE_WIDTH-1:0]     retire,
    output rob_alloc_t                      alloc,
    output logic                            free_empty
);

    localparam int NUM_AREGS = 1 << `AREG_BITS;
    localparam int NUM_PREGS = 1 << `PREG_BITS;

    // speculative mapping, areg -> preg
    logic [`PREG_BITS-1:0]      map_table [NUM_AREGS];

    // ring of free physical indices
    logic [`PREG_BITS-1:0]      free_list [NUM_PREGS];
    logic [`PREG_BITS-1:0]      fl_head;
    logic [`PREG_BITS-1:0]      fl_tail;
    logic [`PREG_BITS:0]        fl_count;

    logic                       do_alloc;
    logic [`RETIRE_WIDTH-1:0]   push_en;
    logic [`PREG_BITS-1:0]      push_idx [`RETIRE_WIDTH];
    logic [`PREG_BITS-1:0]      tail_next;
    logic [`PREG_BITS:0]        n_release;

    assign free_empty = (fl_count == '0);

    // stores have no destination, so they neither pop nor remap
    assign do_alloc = dispatch.valid && !dispatch.is_store;

    ////////////////////////////////////////////////////////////
    // allocation, combinational from dispatch and map table
    ////////////////////////////////////////////////////////////

    always_comb begin
        alloc          = '0;
        alloc.valid    = dispatch.valid;
        alloc.areg     = dispatch.areg;
        alloc.is_store = dispatch.is_store;
        alloc.pc       = dispatch.pc;
        if (!dispatch.is_store) begin
            alloc.preg_new = free_list[fl_head];
            alloc.preg_old = map_table[dispatch.areg];
        end
    end

    ////////////////////////////////////////////////////////////
    // release, pack retired old pregs onto the tail
    ////////////////////////////////////////////////////////////

    always_comb begin
        tail_next = fl_tail;
        n_release = '0;
        for (int s = 0; s < `RETIRE_WIDTH; s++) begin
            push_en[s]  = retire[s].valid && !retire[s].is_store;
            push_idx[s] = tail_next;
            if (push_en[s]) begin
                tail_next = tail_next + 1'b1;
                n_release = n_release + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int r = 0; r < NUM_AREGS; r++) begin
                map_table[r] <= `PREG_BITS'(r);                 // identity
            end
            for (int i = 0; i < NUM_PREGS; i++) begin
                if (i < NUM_AREGS) begin
                    free_list[i] <= `PREG_BITS'(NUM_AREGS + i);  // p32..p63 free
                end else begin
                    free_list[i] <= '0;
                end
            end
            fl_head  <= '0;
            fl_tail  <= `PREG_BITS'(NUM_AREGS);
            fl_count <= (`PREG_BITS+1)'(NUM_AREGS);
        end else begin
            if (do_alloc) begin
                map_table[dispatch.areg] <= free_list[fl_head];
                fl_head                  <= fl_head + 1'b1;
            end

            for (int s = 0; s < `RETIRE_WIDTH; s++) begin
                if (push_en[s]) begin
                    free_list[push_idx[s]] <= retire[s].preg_old;
                end
            end
            fl_tail <= tail_next;

            // pop and push may land on the same edge
            fl_count <= fl_count + n_release - {{`PREG_BITS{1'b0}}, do_alloc};
        end
    end

endmodule

//--- verilog/reorder_buffer.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module reorder_buffer
    import rob_pkg::*;
(
    input  logic                            clk,
    input  logic                            rstn,
    input  rob_alloc_t                      alloc,
    input  complete_t [`CPL_PORTS-1:0]      complete,
    output logic                            rob_full,
    output logic [`ROB_BITS-1:0]            tail_tag,
    output retire_t [`RETIRE_WIDTH-1:0]     retire
);

    rob_entry_t                     entries [`ROB_DEPTH];
    logic [`ROB_BITS-1:0]           head;
    logic [`ROB_BITS-1:0]           tail;
    logic [`ROB_BITS:0]             count;

    rob_entry_t                     new_entry;
    logic                           in_order;
    logic [`RETIRE_WIDTH-1:0]       ret_en;
    logic [`ROB_BITS-1:0]           ret_idx [`RETIRE_WIDTH];
    logic [`ROB_BITS:0]             n_retire;
    retire_t [`RETIRE_WIDTH-1:0]    retire_d;

    assign rob_full = (count == `ROB_DEPTH);
    assign tail_tag = tail;                     // tag handed to this dispatch

    ////////////////////////////////////////////////////////////
    // dispatch record
    ////////////////////////////////////////////////////////////

    always_comb begin
        new_entry          = '0;
        new_entry.busy     = 1'b1;
        new_entry.areg     = alloc.areg;
        new_entry.preg_new = alloc.preg_new;
        new_entry.preg_old = alloc.preg_old;
        new_entry.is_store = alloc.is_store;
        new_entry.pc       = alloc.pc;
    end

    ////////////////////////////////////////////////////////////
    // retirement select
    ////////////////////////////////////////////////////////////

    // head first, a younger slot only behind a retiring older one
    always_comb begin
        in_order = 1'b1;
        n_retire = '0;
        retire_d = '0;
        for (int s = 0; s < `RETIRE_WIDTH; s++) begin
            ret_idx[s] = head + `ROB_BITS'(s);
            ret_en[s]  = in_order && entries[ret_idx[s]].busy && entries[ret_idx[s]].done;
            in_order   = ret_en[s];
            if (ret_en[s]) begin
                retire_d[s].valid    = 1'b1;
                retire_d[s].areg     = entries[ret_idx[s]].areg;
                retire_d[s].preg_old = entries[ret_idx[s]].preg_old;
                retire_d[s].data     = entries[ret_idx[s]].data;
                retire_d[s].pc       = entries[ret_idx[s]].pc;
                retire_d[s].is_store = entries[ret_idx[s]].is_store;
                n_retire             = n_retire + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // entry store and pointers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                entries[i] <= '0;
            end
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            retire <= '0;
        end else begin
            retire <= retire_d;        // valids pulse for one cycle

            // free the slots that just retired
            for (int s = 0; s < `RETIRE_WIDTH; s++) begin
                if (ret_en[s]) begin
                    entries[ret_idx[s]].busy <= 1'b0;
                    entries[ret_idx[s]].done <= 1'b0;
                end
            end

            // tail slot is never busy here, full already stalls dispatch
            if (alloc.valid) begin
                entries[tail] <= new_entry;
                tail          <= tail + 1'b1;
            end

            // tagged writeback, one port per tag per cycle
            for (int p = 0; p < `CPL_PORTS; p++) begin
                if (complete[p].valid) begin
                    entries[complete[p].tag].done <= 1'b1;
                    entries[complete[p].tag].data <= complete[p].data;
                end
            end

            head  <= head + n_retire[`ROB_BITS-1:0];
            count <= count + {{`ROB_BITS{1'b0}}, alloc.valid} - n_retire;
        end
    end

endmodule

//--- verilog/arch_reg_file.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module arch_reg_file
    import rob_pkg::*;
(
    input  logic                            clk,
    input  logic                            rstn,
    input  retire_t [`RETIRE_WIDTH-1:0]     retire,
    input  logic [`AREG_BITS-1:0]           rd_addr,
    output logic [`XLEN-1:0]                rd_data
);

    localparam int NUM_AREGS = 1 << `AREG_BITS;

    logic [`XLEN-1:0] regs [NUM_AREGS];

    // committed state, later slot overwrites an earlier one
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int r = 0; r < NUM_AREGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int s = 0; s < `RETIRE_WIDTH; s++) begin
                if (retire[s].valid && !retire[s].is_store && retire[s].areg != '0) begin
                    regs[retire[s].areg] <= retire[s].data;
                end
            end
        end
    end

    // r0 is hardwired zero
    assign rd_data = (rd_addr == '0) ? '0 : regs[rd_addr];

endmodule

//--- verilog/retire_core.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module retire_core
    import rob_pkg::*;
(
    input  logic                            clk,
    input  logic                            rstn,
    input  dispatch_t                       dispatch,
    output logic                            stall,
    output logic [`ROB_BITS-1:0]            dispatch_tag,
    input  complete_t [`CPL_PORTS-1:0]      complete,
    output retire_t [`RETIRE_WIDTH-1:0]     retire,
    input  logic [`AREG_BITS-1:0]           rd_addr,
    output logic [`XLEN-1:0]                rd_data
);

    dispatch_t      dispatch_ok;    // dispatch with valid masked by stall
    rob_alloc_t     alloc;
    logic           rob_full;
    logic           free_empty;

    assign stall = rob_full | free_empty;

    always_comb begin
        dispatch_ok       = dispatch;
        dispatch_ok.valid = dispatch.valid && !stall;
    end

    rename_unit rename_unit_inst (
        .clk        (clk),
        .rstn       (rstn),
        .dispatch   (dispatch_ok),
        .retire     (retire),
        .alloc      (alloc),
        .free_empty (free_empty)
    );

    reorder_buffer reorder_buffer_inst (
        .clk        (clk),
        .rstn       (rstn),
        .alloc      (alloc),
        .complete   (complete),
        .rob_full   (rob_full),
        .tail_tag   (dispatch_tag),
        .retire     (retire)
    );

    arch_reg_file arch_reg_file_inst (
        .clk        (clk),
        .rstn       (rstn),
        .retire     (retire),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

endmodule

//--- bench/tb_retire_core.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module tb_retire_core
    import rob_pkg::*;
();

    localparam int NUM_AREGS = 1 << `AREG_BITS;

    // one cycle of stimulus
    typedef struct packed {
        logic                           dv;
        logic [`AREG_BITS-1:0]          areg;
        logic                           st;
        logic [`XLEN-1:0]               pc;
        logic [`CPL_PORTS-1:0]          cv;     // port in use
        logic [`CPL_PORTS-1:0][7:0]     cseq;   // sequence number it completes
        logic [`AREG_BITS-1:0]          rd;
    } row_t;

    logic                           clk;
    logic                           rstn;
    dispatch_t                      dispatch;
    logic                           stall;
    logic [`ROB_BITS-1:0]           dispatch_tag;
    complete_t [`CPL_PORTS-1:0]     complete;
    retire_t [`RETIRE_WIDTH-1:0]    retire;
    logic [`AREG_BITS-1:0]          rd_addr;
    logic [`XLEN-1:0]               rd_data;

    row_t           rows [$];
    logic           table_ready;
    int             seq_next;
    int             rd_fix;         // register to watch or -1 to sweep all
    int             mismatches;
    int             failures;
    logic [31:0]    lcg_state;

    ////////////////////////////////////////////////////////////
    // reference model state
    ////////////////////////////////////////////////////////////

    int                             rob_q [$];          // seq numbers with the oldest first
    logic [`PREG_BITS-1:0]          free_q [$];
    logic [`PREG_BITS-1:0]          map_m [NUM_AREGS];
    logic [`XLEN-1:0]               shadow [NUM_AREGS];
    retire_t [`RETIRE_WIDTH-1:0]    pend;               // retire shown next cycle
    int                             pend_seq [`RETIRE_WIDTH];
    int                             drv_seq [`CPL_PORTS];
    int                             acc_count;
    byte                            m_state [256];      // 1 waiting, 2 done, 3 retired
    logic                           seen_ret [256];
    logic [`AREG_BITS-1:0]          m_areg [256];
    logic                           m_st [256];
    logic [`PREG_BITS-1:0]          m_pold [256];
    logic [`XLEN-1:0]               m_pc [256];
    logic [`XLEN-1:0]               m_data [256];

    retire_core retire_core_inst (
        .clk          (clk),
        .rstn         (rstn),
        .dispatch     (dispatch),
        .stall        (stall),
        .dispatch_tag (dispatch_tag),
        .complete     (complete),
        .retire       (retire),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    ////////////////////////////////////////////////////////////
    // table construction
    ////////////////////////////////////////////////////////////

    function automatic int add_row(input logic dv, input int areg, input logic st,
                                   input int pc, input int c0, input int c1,
                                   input int c2, input int c3);
        row_t r;
        int   c [`CPL_PORTS];
        c = '{c0, c1, c2, c3};
        r = '0;
        r.dv   = dv;
        r.areg = `AREG_BITS'(areg);
        r.st   = st;
        r.pc   = `XLEN'(pc);
        for (int p = 0; p < `CPL_PORTS; p++) begin
            if (c[p] >= 0) begin
                r.cv[p]   = 1'b1;
                r.cseq[p] = 8'(c[p]);
            end
        end
        r.rd = `AREG_BITS'((rd_fix >= 0) ? rd_fix : rows.size() % NUM_AREGS);
        rows.push_back(r);
        if (dv) begin
            seq_next++;
            return seq_next - 1;
        end
        return -1;
    endfunction

    function automatic int dispatch_row(input int areg, input logic st);
        return add_row(1'b1, areg, st, 32'h1000 + 4 * rows.size(), -1, -1, -1, -1);
    endfunction

    function automatic void complete_row(input int c0, input int c1, input int c2, input int c3);
        void'(add_row(1'b0, 0, 1'b0, 0, c0, c1, c2, c3));
    endfunction

    function automatic void idle_rows(input int n);
        for (int i = 0; i < n; i++) begin
            void'(add_row(1'b0, 0, 1'b0, 0, -1, -1, -1, -1));
        end
    endfunction

    task automatic build_table();
        int s [16];
        int a;
        int b;
        int prev1;
        int prev2;
        rd_fix = -1;
        idle_rows(NUM_AREGS);                       // all registers read zero
        for (int k = 0; k < 4; k++) begin           // single instructions
            rd_fix = k + 1;
            a = dispatch_row(k + 1, 1'b0);
            idle_rows(1);
            complete_row(a, -1, -1, -1);
            idle_rows(3);
        end
        rd_fix = -1;
        for (int k = 0; k < 8; k++) s[k] = dispatch_row(8 + k, 1'b0);
        complete_row(s[7], s[6], s[5], s[4]);       // reverse order
        complete_row(s[3], s[2], s[1], s[0]);
        idle_rows(5);
        for (int k = 0; k < 16; k++) s[k] = dispatch_row(16 + k, 1'b0);
        for (int k = 0; k < 3; k++) begin
            void'(dispatch_row(3, 1'b0));
            seq_next--;                             // dropped offer takes no seq
        end
        complete_row(s[0], -1, -1, -1);
        idle_rows(2);
        complete_row(s[1], s[2], s[3], s[4]);
        complete_row(s[5], s[6], s[7], s[8]);
        complete_row(s[9], s[10], s[11], s[12]);
        complete_row(s[13], s[14], s[15], -1);
        idle_rows(6);
        rd_fix = 5;
        for (int k = 0; k < 2; k++) begin           // write r5 then a store to r5
            a = dispatch_row(5, k == 1);
            idle_rows(1);
            complete_row(a, -1, -1, -1);
            idle_rows(3);
        end
        rd_fix = 6;
        a = dispatch_row(6, 1'b0);
        b = dispatch_row(6, 1'b0);
        complete_row(a, b, -1, -1);                 // slot 1 wins in the same cycle
        idle_rows(4);
        rd_fix = 7;
        prev1 = -1;
        prev2 = -1;
        for (int k = 0; k < 40; k++) begin          // two-pc loop on r7
            a = add_row(1'b1, 7, 1'b0, 32'h2000 + 4 * (k % 2), prev2, -1, -1, -1);
            prev2 = prev1;
            prev1 = a;
        end
        complete_row(prev2, prev1, -1, -1);
        idle_rows(6);
    endtask

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_retire(input int slot, input retire_t exp, input retire_t act);
        if (act.valid !== 1'b0 && !exp.valid) begin
            $display("unexpected retire valid on slot %0d at %0t", slot, $time);
            failures++;
        end else if (exp.valid && act.valid !== 1'b1) begin
            $display("retirement of pc %h missing on slot %0d at %0t", exp.pc, slot, $time);
            failures++;
        end else if (exp.valid && act !== exp) begin
            $display("MISMATCH at %0t: retire[%0d] areg %0d preg_old %0d data %h pc %h st %b",
                     $time, slot, act.areg, act.preg_old, act.data, act.pc, act.is_store);
            $display("    expected areg %0d preg_old %0d data %h pc %h st %b",
                     exp.areg, exp.preg_old, exp.data, exp.pc, exp.is_store);
            mismatches++;
        end
    endtask

    task automatic check_stall(input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: stall is %b, expected %b", $time, act, exp);
            mismatches++;
        end
    endtask

    task automatic check_tag(input logic [`ROB_BITS-1:0] exp, input logic [`ROB_BITS-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: dispatch_tag is %0d, expected %0d", $time, act, exp);
            mismatches++;
        end
    endtask

    task automatic check_reg(input int addr, input logic [`XLEN-1:0] exp,
                             input logic [`XLEN-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: r%0d reads %h, expected %h", $time, addr, act, exp);
            mismatches++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // drive one row then check and advance the model
    ////////////////////////////////////////////////////////////

    task automatic apply_row(input row_t r);
        dispatch_t                  d;
        complete_t [`CPL_PORTS-1:0] c;
        int                         sq;
        d = '0;
        d.valid    = r.dv;
        d.areg     = r.areg;
        d.is_store = r.st;
        d.pc       = r.pc;
        c = '0;
        for (int p = 0; p < `CPL_PORTS; p++) begin
            drv_seq[p] = -1;
            if (r.cv[p]) begin
                sq = int'(r.cseq[p]);
                if (m_state[sq] != 1) begin
                    $display("table completes seq %0d, which is not waiting", sq);
                    failures++;
                end else begin
                    c[p].valid = 1'b1;
                    c[p].tag   = `ROB_BITS'(sq % `ROB_DEPTH);
                    c[p].data  = lcg_next();
                    m_data[sq] = c[p].data;
                    drv_seq[p] = sq;
                end
            end
        end
        dispatch <= d;
        complete <= c;
        rd_addr  <= r.rd;
    endtask

    task automatic step_model(input row_t r);
        logic stall_m;
        int   sq;
        stall_m = (rob_q.size() == `ROB_DEPTH) || (free_q.size() == 0);
        check_stall(stall_m, stall);
        check_tag(`ROB_BITS'(acc_count), dispatch_tag);
        check_reg(int'(r.rd), shadow[r.rd], rd_data);
        for (int s = 0; s < `RETIRE_WIDTH; s++) begin
            check_retire(s, pend[s], retire[s]);
            if (pend[s].valid && retire[s] === pend[s]) seen_ret[pend_seq[s]] = 1'b1;
        end
        if (retire[1].valid && !retire[0].valid) begin
            $display("slot 1 retired without slot 0 at %0t", $time);
            failures++;
        end
        // register write and old preg release at the coming edge
        for (int s = 0; s < `RETIRE_WIDTH; s++) begin
            if (pend[s].valid && !pend[s].is_store) begin
                if (pend[s].areg != '0) shadow[pend[s].areg] = pend[s].data;
                free_q.push_back(pend[s].preg_old);
            end
        end
        // in-order pick from done flags before this cycle's completions
        for (int s = 0; s < `RETIRE_WIDTH; s++) begin
            pend[s]     = '0;
            pend_seq[s] = -1;
            if ((s == 0 || pend[0].valid) && rob_q.size() > 0 && m_state[rob_q[0]] == 2) begin
                sq               = rob_q.pop_front();
                m_state[sq]      = 3;
                pend_seq[s]      = sq;
                pend[s].valid    = 1'b1;
                pend[s].areg     = m_areg[sq];
                pend[s].preg_old = m_pold[sq];
                pend[s].data     = m_data[sq];
                pend[s].pc       = m_pc[sq];
                pend[s].is_store = m_st[sq];
            end
        end
        for (int p = 0; p < `CPL_PORTS; p++) begin
            if (drv_seq[p] >= 0) m_state[drv_seq[p]] = 2;
        end
        if (r.dv && !stall_m) begin
            sq          = acc_count;
            acc_count   = acc_count + 1;
            m_state[sq] = 1;
            m_areg[sq]  = r.areg;
            m_st[sq]    = r.st;
            m_pc[sq]    = r.pc;
            m_pold[sq]  = '0;                       // stores carry no destination
            if (!r.st) begin
                m_pold[sq]     = map_m[r.areg];
                map_m[r.areg]  = free_q.pop_front();
            end
            rob_q.push_back(sq);
        end
    endtask

    initial begin
        wait (table_ready === 1'b1);
        repeat (rows.size() + 40) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", rows.size() + 40);
        $display("Errors found");
        $finish;
    end

    initial begin
        rstn      = 1'b0;
        dispatch  = '0;
        complete  = '0;
        rd_addr   = '0;
        lcg_state = 32'd68;
        seq_next  = 0;
        acc_count = 0;
        mismatches = 0;
        failures   = 0;
        pend      = '0;
        table_ready = 1'b0;
        for (int i = 0; i < 256; i++) begin
            m_state[i]  = 0;
            seen_ret[i] = 1'b0;
        end
        for (int i = 0; i < NUM_AREGS; i++) begin
            map_m[i]  = `PREG_BITS'(i);             // identity after reset
            shadow[i] = '0;
            free_q.push_back(`PREG_BITS'(NUM_AREGS + i));
        end
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        foreach (rows[i]) begin
            apply_row(rows[i]);
            @(negedge clk);
            step_model(rows[i]);
            @(posedge clk);
        end
        for (int i = 0; i < acc_count; i++) begin
            if (m_state[i] >= 2 && !seen_ret[i]) begin
                $display("seq %0d with tag %0d was completed but never retired", i,
                         i % `ROB_DEPTH);
                failures++;
            end
        end
        $display("mismatches %0d, other failures %0d", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
verilog/rob_pkg.sv
verilog/rename_unit.sv
verilog/reorder_buffer.sv
verilog/arch_reg_file.sv
verilog/retire_core.sv
bench/tb_retire_core.sv
